// ==== common/imem_pkg.sv ====
`default_nettype none

package imem_pkg;

    // ------------------------------------------------------------
    // Bus widths and line geometry.
    // ------------------------------------------------------------
    localparam int ADDR_W    = 32;                 // Byte address on AR.
    localparam int DATA_W    = 32;                 // One word per beat.
    localparam int LINE_W    = 256;                // Cache line seen by the core.
    localparam int MAX_BURST = LINE_W / DATA_W;    // Words per line.
    localparam int IDX_W     = $clog2(MAX_BURST);  // Beat index within a line.
    localparam int LEN_W     = IDX_W + 1;          // Word count, 1 up to MAX_BURST.

    // ------------------------------------------------------------
    // Fixed read-address attributes.
    // ------------------------------------------------------------
    // Beat size is the full data bus.
    localparam logic [2:0] AR_SIZE  = 3'($clog2(DATA_W / 8));
    localparam logic [1:0] AR_BURST = 2'b01;       // INCR.
    localparam logic [3:0] AR_CACHE = 4'b0010;     // Modifiable, non-bufferable.
    localparam logic [2:0] AR_PROT  = 3'b000;      // Unprivileged, secure, data.
    localparam logic [3:0] AR_QOS   = 4'b0000;     // No QoS class.
    localparam logic       AR_LOCK  = 1'b0;        // Normal access.

    // ------------------------------------------------------------
    // Cache line, two views of the same bits.
    // ------------------------------------------------------------
    // The word view runs 0 to MAX_BURST-1 from the left, so beat 0
    // lands in the most significant word of the flat view.
    typedef union packed {
        logic [LINE_W-1:0]                flat;   // As the core reads it.
        logic [0:MAX_BURST-1][DATA_W-1:0] words;  // As the bus fills it.
    } line_t;

    // Request controller states.
    typedef enum logic [1:0] {
        IDLE,   // Waiting for a fetch strobe.
        READ,   // Burst in flight.
        DONE    // Line presented for one cycle.
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== common/burst_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One burst request from the controller and its completion from the channels.
interface burst_if;
    import imem_pkg::*;

    logic              start;      // Single-cycle kick for a new burst.
    logic [ADDR_W-1:0] addr;       // Line address, held for the request.
    logic [LEN_W-1:0]  len;        // Words to fetch, not length minus one.
    logic              last_beat;  // Final beat accepted this cycle.
    logic              error;      // Sticky response error for this burst.

    // Request side.
    modport ctrl (
        output start,
        output addr,
        output len,
        input  last_beat,
        input  error
    );

    // AR and R side; each channel reads only the fields it needs.
    modport chan (
        input  start,
        input  addr,
        input  len,
        output last_beat,
        output error
    );

endinterface

`default_nettype wire

// ==== fetch/fetch_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
    input  wire                         M_AXI_ACLK,
    input  wire                         M_AXI_ARESETN,
    input  wire                         strobe,    // Sampled in IDLE only.
    input  wire  [imem_pkg::ADDR_W-1:0] addr,
    input  wire  [imem_pkg::LEN_W-1:0]  len,
    input  wire  imem_pkg::line_t       line_in,   // Buffer contents.
    burst_if.ctrl                       burst,
    output logic                        done,
    output imem_pkg::line_t             line,
    output logic                        error
);
    import imem_pkg::*;

    ctrl_state_t       state;
    ctrl_state_t       state_nxt;
    logic [ADDR_W-1:0] addr_q;     // Captured at the strobe.
    logic [LEN_W-1:0]  len_q;      // Captured at the strobe.
    logic              start_q;    // High in the first READ cycle.
    logic              take;       // Strobe accepted this cycle.

    assign take = (state == IDLE) && strobe;

    // ------------------------------------------------------------
    // State register and next-state logic.
    // ------------------------------------------------------------
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE:    if (strobe) state_nxt = READ;
            READ:    if (burst.last_beat) state_nxt = DONE;  // Line complete.
            DONE:    state_nxt = IDLE;                       // One cycle only.
            default: state_nxt = IDLE;
        endcase
    end

    // Burst kick, one cycle behind the accepted strobe.
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
            start_q <= 1'b0;
        else
            start_q <= take;
    end

    // Request fields stay fixed for the whole burst.
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (take)
        begin
            addr_q <= addr;
            len_q  <= len;
        end
    end

    assign burst.start = start_q;
    assign burst.addr  = addr_q;
    assign burst.len   = len_q;

    // ------------------------------------------------------------
    // Core-side outputs.
    // ------------------------------------------------------------
    assign done      = (state == DONE);                   // Decoded from the state flop.
    assign error     = done & burst.error;                // Includes the last beat.
    assign line.flat = done ? line_in.flat : {LINE_W{1'b0}};  // Zero between requests.

endmodule

`default_nettype wire

// ==== axi_read/ar_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

module ar_channel (
    input  wire                         M_AXI_ACLK,
    input  wire                         M_AXI_ARESETN,
    burst_if.chan                       burst,
    output logic [imem_pkg::ADDR_W-1:0] araddr,
    output logic [7:0]                  arlen,     // Beats minus one.
    output logic                        arvalid,
    input  wire                         arready
);

    // ------------------------------------------------------------
    // Address and length.
    // ------------------------------------------------------------
    // Loaded at start and held steady while ARVALID waits.
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (burst.start)
        begin
            araddr <= burst.addr;
            arlen  <= 8'(burst.len) - 8'd1;   // Word count to AXI length form.
        end
    end

    // ------------------------------------------------------------
    // Valid handshake.
    // ------------------------------------------------------------
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
            arvalid <= 1'b0;
        else if (burst.start)
            arvalid <= 1'b1;                  // New request.
        else if (arready)
            arvalid <= 1'b0;                  // Accepted, drop next cycle.
    end

endmodule

`default_nettype wire

// ==== axi_read/r_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

module r_channel (
    input  wire                         M_AXI_ACLK,
    input  wire                         M_AXI_ARESETN,
    burst_if.chan                       burst,
    input  wire  [imem_pkg::DATA_W-1:0] rdata,
    input  wire  [1:0]                  rresp,
    input  wire                         rvalid,
    output logic                        rready,
    output logic                        wr_en,     // Store this beat.
    output logic [imem_pkg::IDX_W-1:0]  wr_idx,    // Word slot.
    output logic [imem_pkg::DATA_W-1:0] wr_word
);
    import imem_pkg::*;

    logic [IDX_W-1:0] idx_q;     // Index of the next beat.
    logic             beat;      // Handshake this cycle.
    logic             at_last;   // Index matches len minus one.

    assign beat    = rvalid && rready;
    assign at_last = ({1'b0, idx_q} == (burst.len - LEN_W'(1)));

    // ------------------------------------------------------------
    // Beat counter.
    // ------------------------------------------------------------
    // RVALID gaps just hold the count; RLAST plays no part.
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
            idx_q <= '0;
        else if (burst.start)
            idx_q <= '0;                 // Fresh burst.
        else if (beat)
            idx_q <= idx_q + 1'b1;
    end

    // Ready held high across the whole burst.
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
            rready <= 1'b0;
        else if (burst.start)
            rready <= 1'b1;
        else if (beat && at_last)
            rready <= 1'b0;              // Last word is in.
    end

    // ------------------------------------------------------------
    // Response error, sticky for one burst.
    // ------------------------------------------------------------
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
            burst.error <= 1'b0;
        else if (burst.start)
            burst.error <= 1'b0;
        else if (beat && rresp[1])
            burst.error <= 1'b1;         // SLVERR or DECERR.
    end

    assign burst.last_beat = beat && at_last;

    // Steer each accepted beat into the line buffer.
    assign wr_en   = beat;
    assign wr_idx  = idx_q;
    assign wr_word = rdata;

endmodule

`default_nettype wire

// ==== axi_read/line_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_buffer (
    input  wire                         M_AXI_ACLK,
    input  wire                         wr_en,
    input  wire  [imem_pkg::IDX_W-1:0]  wr_idx,
    input  wire  [imem_pkg::DATA_W-1:0] wr_word,
    output imem_pkg::line_t             line
);
    import imem_pkg::*;

    line_t buf_q;   // Eight words, beat 0 on top.

    // ------------------------------------------------------------
    // Word writes.
    // ------------------------------------------------------------
    // Unwritten slots keep whatever an earlier request left there,
    // so a short burst only refreshes the upper words.
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (wr_en)
            buf_q.words[wr_idx] <= wr_word;
    end

    assign line.flat = buf_q.flat;  // Whole line out.

endmodule

`default_nettype wire

// ==== src/imem_port_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module imem_port_top (
    input  wire                         M_AXI_ACLK,
    input  wire                         M_AXI_ARESETN,

    // Core side.
    input  wire                         imem_strobe,     // Fetch request.
    input  wire  [imem_pkg::ADDR_W-1:0] imem_addr,       // Line address.
    input  wire  [imem_pkg::LEN_W-1:0]  imem_burst_len,  // Words, 1 to 8.
    output logic                        imem_done,       // One-cycle completion.
    output logic [imem_pkg::LINE_W-1:0] imem_line,       // Zero outside done.
    output logic                        imem_error,      // Valid with done.

    // Read address channel.
    output logic [imem_pkg::ADDR_W-1:0] M_AXI_ARADDR,
    output logic [7:0]                  M_AXI_ARLEN,
    output logic [2:0]                  M_AXI_ARSIZE,
    output logic [1:0]                  M_AXI_ARBURST,
    output logic                        M_AXI_ARLOCK,
    output logic [3:0]                  M_AXI_ARCACHE,
    output logic [2:0]                  M_AXI_ARPROT,
    output logic [3:0]                  M_AXI_ARQOS,
    output logic                        M_AXI_ARVALID,
    input  wire                         M_AXI_ARREADY,

    // Read data channel.
    input  wire  [imem_pkg::DATA_W-1:0] M_AXI_RDATA,
    input  wire  [1:0]                  M_AXI_RRESP,
    input  wire                         M_AXI_RLAST,     // Beats are counted instead.
    input  wire                         M_AXI_RVALID,
    output logic                        M_AXI_RREADY
);
    import imem_pkg::*;

    burst_if u_burst ();               // Controller to channel link.

    line_t             buf_line;       // Raw buffer contents.
    line_t             out_line;       // Gated line from the controller.
    logic              wr_en;          // Beat accepted.
    logic [IDX_W-1:0]  wr_idx;         // Word slot for the beat.
    logic [DATA_W-1:0] wr_word;        // Beat payload.

    // ------------------------------------------------------------
    // Fixed AR attributes.
    // ------------------------------------------------------------
    assign M_AXI_ARSIZE  = AR_SIZE;
    assign M_AXI_ARBURST = AR_BURST;
    assign M_AXI_ARLOCK  = AR_LOCK;
    assign M_AXI_ARCACHE = AR_CACHE;
    assign M_AXI_ARPROT  = AR_PROT;
    assign M_AXI_ARQOS   = AR_QOS;

    assign imem_line = out_line.flat;  // Core sees the flat view.

    // ------------------------------------------------------------
    // Request controller.
    // ------------------------------------------------------------
    fetch_ctrl u_fetch_ctrl (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .strobe        (imem_strobe),
        .addr          (imem_addr),
        .len           (imem_burst_len),
        .line_in       (buf_line),
        .burst         (u_burst.ctrl),
        .done          (imem_done),
        .line          (out_line),
        .error         (imem_error)
    );

    // ------------------------------------------------------------
    // AXI read channels and line storage.
    // ------------------------------------------------------------
    ar_channel u_ar_channel (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .burst         (u_burst.chan),
        .araddr        (M_AXI_ARADDR),
        .arlen         (M_AXI_ARLEN),
        .arvalid       (M_AXI_ARVALID),
        .arready       (M_AXI_ARREADY)
    );

    r_channel u_r_channel (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .burst         (u_burst.chan),
        .rdata         (M_AXI_RDATA),
        .rresp         (M_AXI_RRESP),
        .rvalid        (M_AXI_RVALID),
        .rready        (M_AXI_RREADY),
        .wr_en         (wr_en),
        .wr_idx        (wr_idx),
        .wr_word       (wr_word)
    );

    line_buffer u_line_buffer (
        .M_AXI_ACLK (M_AXI_ACLK),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_word    (wr_word),
        .line       (buf_line)
    );

endmodule

`default_nettype wire

// ==== tests/tb_axi_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

// Behavioral AXI read slave with a word memory, stall and error knobs.
module tb_axi_slave (
    input  wire                         M_AXI_ACLK,
    input  wire                         M_AXI_ARESETN,
    input  wire  [imem_pkg::ADDR_W-1:0] M_AXI_ARADDR,
    input  wire  [7:0]                  M_AXI_ARLEN,
    input  wire                         M_AXI_ARVALID,
    output logic                        M_AXI_ARREADY,
    output logic [imem_pkg::DATA_W-1:0] M_AXI_RDATA,
    output logic [1:0]                  M_AXI_RRESP,
    output logic                        M_AXI_RLAST,
    output logic                        M_AXI_RVALID,
    input  wire                         M_AXI_RREADY,
    input  wire  [3:0]                  ar_stall,   // Cycles ARREADY stays low.
    input  wire                         gap_en,     // Random RVALID gaps.
    input  wire  [3:0]                  err_beat,   // Beat answered with SLVERR.
    output int                          ar_count    // Accepted AR requests.
);
    import imem_pkg::*;

    logic [DATA_W-1:0] mem [0:63];   // Word memory, wraps every 256 bytes.
    integer            seed;
    logic [5:0]        base;         // First word of the burst.
    logic [7:0]        last_n;       // ARLEN of the burst.
    logic [7:0]        beat_n;       // Beat now on the bus.
    logic              active;       // Burst accepted and not finished.
    logic              ar_hs;
    logic              r_hs;
    int                stall_n;

    initial
    begin
        seed = 32'hbbb26b21;
        for (int i = 0; i < 64; i++)
            mem[i] = $random(seed);
        M_AXI_ARREADY = 1'b0;
        M_AXI_RDATA   = '0;
        M_AXI_RRESP   = 2'b00;
        M_AXI_RLAST   = 1'b0;
        M_AXI_RVALID  = 1'b0;
        ar_count      = 0;
        active        = 1'b0;
        beat_n        = '0;
        last_n        = '0;
        base          = '0;
        stall_n       = 0;
        forever
        begin
            @(posedge M_AXI_ACLK);
            ar_hs = M_AXI_ARVALID && M_AXI_ARREADY;   // Handshakes seen at the edge.
            r_hs  = M_AXI_RVALID && M_AXI_RREADY;
            #1;
            if (!M_AXI_ARESETN)
            begin
                M_AXI_ARREADY = 1'b0;
                M_AXI_RVALID  = 1'b0;
                active        = 1'b0;
                stall_n       = 0;
            end
            else
            begin
                if (r_hs)
                begin
                    M_AXI_RVALID = 1'b0;
                    active       = (beat_n != last_n);   // Stop after ARLEN.
                    beat_n       = beat_n + 8'd1;
                end
                if (ar_hs)
                begin
                    M_AXI_ARREADY = 1'b0;
                    base          = M_AXI_ARADDR[7:2];
                    last_n        = M_AXI_ARLEN;
                    beat_n        = '0;
                    active        = 1'b1;
                    stall_n       = 0;
                    ar_count++;
                end
                else if (M_AXI_ARVALID)
                begin
                    if (stall_n >= ar_stall)
                        M_AXI_ARREADY = 1'b1;
                    else
                        stall_n++;                       // Hold off the request.
                end
                // Next beat, with an optional random gap.
                if (active && !M_AXI_RVALID && (!gap_en || ($random(seed) & 1)))
                begin
                    M_AXI_RVALID = 1'b1;
                    M_AXI_RDATA  = mem[base + beat_n[5:0]];
                    M_AXI_RRESP  = (beat_n == err_beat) ? 2'b10 : 2'b00;
                    M_AXI_RLAST  = (beat_n == last_n);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_imem_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_imem_port;
    import imem_pkg::*;

    localparam int TIMEOUT = 200;           // Cycles allowed for any wait.
    localparam int AR_W    = ADDR_W + 25;   // ARADDR down to ARQOS.

    logic              M_AXI_ACLK;
    logic              M_AXI_ARESETN;
    logic              imem_strobe;
    logic [ADDR_W-1:0] imem_addr;
    logic [LEN_W-1:0]  imem_burst_len;
    logic              imem_done;
    logic [LINE_W-1:0] imem_line;
    logic              imem_error;
    logic [ADDR_W-1:0] M_AXI_ARADDR;
    logic [7:0]        M_AXI_ARLEN;
    logic [2:0]        M_AXI_ARSIZE;
    logic [1:0]        M_AXI_ARBURST;
    logic              M_AXI_ARLOCK;
    logic [3:0]        M_AXI_ARCACHE;
    logic [2:0]        M_AXI_ARPROT;
    logic [3:0]        M_AXI_ARQOS;
    logic              M_AXI_ARVALID;
    logic              M_AXI_ARREADY;
    logic [DATA_W-1:0] M_AXI_RDATA;
    logic [1:0]        M_AXI_RRESP;
    logic              M_AXI_RLAST;
    logic              M_AXI_RVALID;
    logic              M_AXI_RREADY;
    logic [3:0]        ar_stall;
    logic              gap_en;
    logic [3:0]        err_beat;
    int                ar_count;

    line_t             model;         // Expected buffer contents.
    line_t             line_seen;
    logic [AR_W-1:0]   ar_seen;       // Fields at the last AR handshake.
    logic [ADDR_W-1:0] araddr_prev;
    logic              ar_waiting;
    logic              last_prev;     // Final beat taken in the previous cycle.
    int                done_count;
    int                wait_count;    // Cycles ARVALID spent waiting.
    string             test_name;     // Test now running.

    imem_port_top u_dut (.*);
    tb_axi_slave  u_slave (.*);

    assign line_seen = imem_line;

    initial
    begin
        M_AXI_ACLK = 1'b0;
        forever #50 M_AXI_ACLK = ~M_AXI_ACLK;
    end

    // ------------------------------------------------------------
    // Failure report and compare tasks.
    // ------------------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t act);
        if (act !== exp)
            abort_run($sformatf("FAIL %s: expected %h, actual %h", name, exp.flat, act.flat));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("FAIL %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic check_attr(input string name, input logic [AR_W-1:0] exp,
                              input logic [AR_W-1:0] act);
        if (act !== exp)
            abort_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp)
            abort_run($sformatf("FAIL %s: expected %0d, actual %0d", name, exp, act));
    endtask

    // Bus monitor sampled mid-cycle.
    always @(negedge M_AXI_ACLK)
    begin
        if (M_AXI_ARESETN)
        begin
            if (imem_done)
                done_count++;
            else
                check_line({test_name, " idle line"}, '0, line_seen);  // Zero between requests.
            if (last_prev)
            begin
                check_flag({test_name, " done after last beat"}, 1'b1, imem_done);
                check_flag({test_name, " RREADY after last beat"}, 1'b0, M_AXI_RREADY);
            end
            if (ar_waiting && M_AXI_ARVALID && M_AXI_ARADDR !== araddr_prev)
                abort_run($sformatf("%s: ARADDR changed while ARVALID waited for ARREADY",
                                    test_name));
            if (M_AXI_ARVALID && M_AXI_ARREADY)
                ar_seen = {M_AXI_ARADDR, M_AXI_ARLEN, M_AXI_ARSIZE, M_AXI_ARBURST,
                           M_AXI_ARLOCK, M_AXI_ARCACHE, M_AXI_ARPROT, M_AXI_ARQOS};
            ar_waiting  = M_AXI_ARVALID && !M_AXI_ARREADY;
            araddr_prev = M_AXI_ARADDR;
            last_prev   = M_AXI_RVALID && M_AXI_RREADY && M_AXI_RLAST;
            if (ar_waiting)
                wait_count++;
        end
    end

    // AXI read attributes for a word-sized INCR burst.
    function automatic logic [AR_W-1:0] ar_expect(input logic [ADDR_W-1:0] addr,
                                                  input int len);
        return {addr, 8'(len - 1), AR_SIZE, AR_BURST, AR_LOCK, AR_CACHE, AR_PROT, AR_QOS};
    endfunction

    // Beat i lands in word i counted from the top of the line.
    task automatic predict(input logic [ADDR_W-1:0] addr, input int len);
        for (int i = 0; i < len; i++)
            model.flat[LINE_W-1-DATA_W*i -: DATA_W] = u_slave.mem[6'(addr[7:2] + i)];
    endtask

    // ------------------------------------------------------------
    // Request helpers.
    // ------------------------------------------------------------
    task automatic wait_done(input string name, output line_t got, output logic err);
        int cycles;
        cycles = 0;
        @(negedge M_AXI_ACLK);
        while (!imem_done && cycles < TIMEOUT)
        begin
            @(negedge M_AXI_ACLK);
            cycles++;
        end
        if (!imem_done)
            abort_run($sformatf("%s: done did not arrive within %0d cycles", name, TIMEOUT));
        got = line_seen;
        err = imem_error;
    endtask

    task automatic fetch_and_check(input string name, input logic [ADDR_W-1:0] addr,
                                   input int len, input logic exp_err);
        line_t got;
        logic  err;
        int    dones;
        test_name = name;
        dones     = done_count;
        predict(addr, len);
        @(posedge M_AXI_ACLK);
        #1;
        imem_strobe    = 1'b1;            // One-cycle fetch strobe.
        imem_addr      = addr;
        imem_burst_len = LEN_W'(len);
        @(posedge M_AXI_ACLK);
        #1;
        imem_strobe = 1'b0;
        wait_done(name, got, err);
        repeat (3) @(posedge M_AXI_ACLK);
        check_line(name, model, got);
        check_flag({name, " error"}, exp_err, err);
        check_attr({name, " AR fields"}, ar_expect(addr, len), ar_seen);
        check_count({name, " done pulses"}, dones + 1, done_count);
    endtask

    // ------------------------------------------------------------
    // Directed tests.
    // ------------------------------------------------------------
    task automatic test_reset_outputs();
        @(negedge M_AXI_ACLK);
        check_flag("reset ARVALID", 1'b0, M_AXI_ARVALID);
        check_flag("reset RREADY", 1'b0, M_AXI_RREADY);
        check_flag("reset done", 1'b0, imem_done);
        check_flag("reset error", 1'b0, imem_error);
    endtask

    task automatic test_full_line();
        fetch_and_check("full line", 32'h0000_0040, 8, 1'b0);
    endtask

    task automatic test_short_burst();
        fetch_and_check("short setup", 32'h0000_00a0, 8, 1'b0);
        fetch_and_check("short burst", 32'h0000_0020, 4, 1'b0);   // Lower half kept.
    endtask

    task automatic test_backpressure();
        int waits;
        waits    = wait_count;
        ar_stall = 4'd6;
        gap_en   = 1'b1;
        fetch_and_check("back-pressure", 32'h0000_00e0, 8, 1'b0);
        check_count("back-pressure AR wait cycles", waits + 6, wait_count);
        ar_stall = 4'd0;
        gap_en   = 1'b0;
    endtask

    task automatic test_read_error();
        err_beat = 4'd2;                                            // SLVERR on beat 2.
        fetch_and_check("read error", 32'h0000_0060, 8, 1'b1);
        err_beat = 4'hf;
        fetch_and_check("error cleared", 32'h0000_0080, 8, 1'b0);
    endtask

    task automatic test_ignored_strobe();
        line_t got;
        logic  err;
        int    dones;
        int    reqs;
        test_name = "held strobe";
        dones     = done_count;
        reqs      = ar_count;
        predict(32'h0000_00c0, 8);
        @(posedge M_AXI_ACLK);
        #1;
        imem_strobe    = 1'b1;            // Held through READ and DONE.
        imem_addr      = 32'h0000_00c0;
        imem_burst_len = 4'd8;
        @(posedge M_AXI_ACLK);
        #1;
        imem_addr      = 32'h0000_0000;   // Request fields were taken at the strobe.
        imem_burst_len = 4'd2;
        wait_done("held strobe", got, err);
        @(posedge M_AXI_ACLK);
        #1;
        imem_strobe = 1'b0;
        repeat (20) @(posedge M_AXI_ACLK);
        check_line("held strobe", model, got);
        check_attr("held strobe AR fields", ar_expect(32'h0000_00c0, 8), ar_seen);
        check_count("held strobe AR requests", reqs + 1, ar_count);
        check_count("held strobe done pulses", dones + 1, done_count);
    endtask

    initial
    begin
        M_AXI_ARESETN  = 1'b0;
        imem_strobe    = 1'b0;
        imem_addr      = '0;
        imem_burst_len = '0;
        ar_stall       = 4'd0;
        gap_en         = 1'b0;
        err_beat       = 4'hf;            // No error beat.
        done_count     = 0;
        wait_count     = 0;
        ar_waiting     = 1'b0;
        last_prev      = 1'b0;
        araddr_prev    = '0;
        ar_seen        = '0;
        test_name      = "reset";
        repeat (5) @(posedge M_AXI_ACLK);
        #1;
        M_AXI_ARESETN = 1'b1;
        test_reset_outputs();
        test_full_line();
        test_short_burst();
        test_backpressure();
        test_read_error();
        test_ignored_strobe();
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
common/imem_pkg.sv
common/burst_if.sv
fetch/fetch_ctrl.sv
axi_read/ar_channel.sv
axi_read/r_channel.sv
axi_read/line_buffer.sv
src/imem_port_top.sv
tests/tb_axi_slave.sv
tests/tb_imem_port.sv

// ==== Bender.yml ====
package:
  name: imem_port

sources:
  - common/imem_pkg.sv
  - common/burst_if.sv
  - fetch/fetch_ctrl.sv
  - axi_read/ar_channel.sv
  - axi_read/r_channel.sv
  - axi_read/line_buffer.sv
  - src/imem_port_top.sv
  - target: test
    files:
      - tests/tb_axi_slave.sv
      - tests/tb_imem_port.sv
